// ==== hdl/mic_meter_defs.svh ====
`ifndef MIC_METER_DEFS_SVH
`define MIC_METER_DEFS_SVH

// --------------------------------------------------
// Board I/O widths

`define W_KEY           4
`define W_SW            10
`define W_LED           18
`define W_DIGIT         4

// Bar graph gets what is left after the decimal points
`define W_BAR           (`W_LED - `W_DIGIT)

// --------------------------------------------------
// Microphone and display timing

`define W_SAMPLE        24      // INMP441 word width

// Half period of the I2S bit clock in clk cycles
`define I2S_SCK_DIV     4

`define SCAN_DIV        16      // Cycles per digit strobe

`endif

// ==== hdl/mic_meter_pkg.sv ====
`default_nettype none

`include "mic_meter_defs.svh"

package mic_meter_pkg;

    // --------------------------------------------------
    // Microphone sample as delivered by the I2S receiver

    typedef struct packed
    {
        logic signed [`W_SAMPLE - 1:0] value;  // Holds until next pulse
        logic                          valid;  // One clk pulse per frame
    } mic_sample_t;

    // --------------------------------------------------
    // Dynamically scanned seven-segment bus

    typedef struct packed
    {
        logic [7:0]            abcdefgh;  // Segment a in MSB, dp in LSB
        logic [`W_DIGIT - 1:0] digit;     // One-hot strobe
    } seg_bus_t;

endpackage

`default_nettype wire

// ==== hdl/i2s_mic_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module i2s_mic_receiver
    import mic_meter_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,
    output logic        sck,
    output logic        ws,
    output mic_sample_t sample
);

    localparam int         div_w     = $clog2(`I2S_SCK_DIV + 1);
    localparam logic [4:0] first_bit = 5'd1;            // One bit clock after ws edge
    localparam logic [4:0] last_bit  = 5'(`W_SAMPLE);

    logic [div_w - 1:0]     div_cnt;
    logic                   sck_edge;
    logic                   sck_rise;
    logic                   sck_fall;
    logic [5:0]             slot_cnt;
    logic [`W_SAMPLE - 1:0] shift_reg;
    logic                   capture;
    logic                   word_done;

    // --------------------------------------------------
    // Bit clock divider

    assign sck_edge = (div_cnt == div_w'(`I2S_SCK_DIV - 1));
    assign sck_rise = sck_edge & ~sck;
    assign sck_fall = sck_edge &  sck;

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_edge)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;

    // --------------------------------------------------
    // Slot counter, 64 bit clocks per frame

    // Starts at the end of a right slot so the first frame is clean
    always_ff @(posedge clk or posedge rst)
        if (rst)
            slot_cnt <= '1;
        else if (sck_fall)
            slot_cnt <= slot_cnt + 1'b1;

    assign ws = slot_cnt[5];                            // Low in the left slot

    // --------------------------------------------------
    // Left slot capture, MSB first

    assign capture = sck_rise & ~ws
                   & (slot_cnt[4:0] >= first_bit)
                   & (slot_cnt[4:0] <= last_bit);

    always_ff @(posedge clk)
        if (capture)
            shift_reg <= {shift_reg[`W_SAMPLE - 2:0], sd};

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            word_done    <= 1'b0;
            sample.valid <= 1'b0;
            sample.value <= '0;
        end
        else
        begin
            word_done    <= capture & (slot_cnt[4:0] == last_bit);
            sample.valid <= word_done;
            if (word_done)
                sample.value <= shift_reg;              // Right slot never lands here
        end

endmodule

`default_nettype wire

// ==== hdl/level_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module level_tracker
    import mic_meter_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  mic_sample_t            sample,
    output logic [`W_SAMPLE - 2:0] peak,
    output logic [`W_BAR - 1:0]    bar
);

    localparam int idx_w    = $clog2(`W_SAMPLE);
    localparam int bar_base = `W_SAMPLE - 2 - `W_BAR;   // MSB index lighting no LED

    logic [`W_SAMPLE - 1:0] abs_full;
    logic [`W_SAMPLE - 2:0] magnitude;
    logic [idx_w - 1:0]     msb_idx;
    logic [idx_w - 1:0]     lit_cnt;

    // --------------------------------------------------
    // Magnitude and peak hold

    assign abs_full  = sample.value[`W_SAMPLE - 1] ? -sample.value : sample.value;
    assign magnitude = abs_full[`W_SAMPLE - 1] ? '1 : abs_full[`W_SAMPLE - 2:0]; // Most negative

    always_ff @(posedge clk or posedge rst)
        if (rst)
            peak <= '0;
        else if (clear)
            peak <= '0;
        else if (sample.valid && magnitude > peak)
            peak <= magnitude;

    // --------------------------------------------------
    // Bar graph from the MSB position of the peak

    always_comb
    begin
        msb_idx = '0;
        for (int i = 0; i < `W_SAMPLE - 1; i++)
            if (peak[i])
                msb_idx = idx_w'(i);                    // Highest set bit wins
    end

    assign lit_cnt = (msb_idx > idx_w'(bar_base)) ? msb_idx - idx_w'(bar_base) : '0;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            bar <= '0;
        else
            for (int i = 0; i < `W_BAR; i++)
                bar[i] <= (idx_w'(i) < lit_cnt);        // Thermometer from LED 0

endmodule

`default_nettype wire

// ==== hdl/seg_scan_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module seg_scan_display
    import mic_meter_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          mode,
    input  logic signed [`W_SAMPLE - 1:0] sample_value,
    input  logic        [`W_SAMPLE - 2:0] peak,
    output seg_bus_t                      seg
);

    localparam int cnt_w  = $clog2(`SCAN_DIV);
    localparam int word_w = 4 * `W_DIGIT;

    logic [cnt_w - 1:0]    scan_cnt;
    logic [`W_DIGIT - 1:0] strobe;
    logic [word_w - 1:0]   word;
    logic [3:0]            nibble;
    logic [6:0]            glyph;
    logic                  dp;

    // --------------------------------------------------
    // Digit scan

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            scan_cnt <= '0;
            strobe   <= `W_DIGIT'(1);
        end
        else if (scan_cnt == cnt_w'(`SCAN_DIV - 1))
        begin
            scan_cnt <= '0;
            strobe   <= {strobe[`W_DIGIT - 2:0], strobe[`W_DIGIT - 1]};
        end
        else
            scan_cnt <= scan_cnt + 1'b1;

    // --------------------------------------------------
    // Word and nibble select

    assign word = mode ? peak[`W_SAMPLE - 2 -: word_w]         // Peak bits 22..7
                       : sample_value[`W_SAMPLE - 1 -: word_w]; // Sample bits 23..8

    always_comb
    begin
        nibble = '0;
        for (int i = 0; i < `W_DIGIT; i++)
            if (strobe[i])
                nibble = word[i * 4 +: 4];
    end

    assign dp = mode & strobe[0];                       // Marks peak mode

    // Hex glyphs, segments abcdefg
    always_comb
        case (nibble)
            4'h0:    glyph = 7'b1111110;
            4'h1:    glyph = 7'b0110000;
            4'h2:    glyph = 7'b1101101;
            4'h3:    glyph = 7'b1111001;
            4'h4:    glyph = 7'b0110011;
            4'h5:    glyph = 7'b1011011;
            4'h6:    glyph = 7'b1011111;
            4'h7:    glyph = 7'b1110000;
            4'h8:    glyph = 7'b1111111;
            4'h9:    glyph = 7'b1111011;
            4'ha:    glyph = 7'b1110111;
            4'hb:    glyph = 7'b0011111;                // Lower case b
            4'hc:    glyph = 7'b1001110;
            4'hd:    glyph = 7'b0111101;                // Lower case d
            4'he:    glyph = 7'b1001111;
            default: glyph = 7'b1000111;
        endcase

    // Strobe delayed along with the glyph
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            seg.abcdefgh <= '0;
            seg.digit    <= `W_DIGIT'(1);
        end
        else
        begin
            seg.abcdefgh <= {glyph, dp};
            seg.digit    <= strobe;
        end

endmodule

`default_nettype wire

// ==== hdl/lab_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module lab_top
    import mic_meter_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [`W_KEY - 1:0] key,
    input  logic [`W_SW  - 2:0] sw,
    output logic [`W_BAR - 1:0] led,
    output seg_bus_t            seg,
    input  logic                mic_sd,
    output logic                mic_sck,
    output logic                mic_ws
);

    mic_sample_t            sample;
    logic [`W_SAMPLE - 2:0] peak;

    // --------------------------------------------------

    i2s_mic_receiver i_receiver
    (
        .clk    ( clk     ),
        .rst    ( rst     ),
        .sd     ( mic_sd  ),
        .sck    ( mic_sck ),
        .ws     ( mic_ws  ),
        .sample ( sample  )
    );

    level_tracker i_tracker
    (
        .clk    ( clk     ),
        .rst    ( rst     ),
        .clear  ( key[0]  ),        // Held key clears the peak
        .sample ( sample  ),
        .peak   ( peak    ),
        .bar    ( led     )
    );

    seg_scan_display i_display
    (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .mode         ( sw[0]        ),   // Up shows the peak
        .sample_value ( sample.value ),
        .peak         ( peak         ),
        .seg          ( seg          )
    );

endmodule

`default_nettype wire

// ==== hdl/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module board_top
    import mic_meter_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic [`W_KEY - 1:0] key_n,
    input  logic [`W_SW  - 1:0] sw,
    output logic [9:0]          ledr,     // Top four carry the decimal points
    output logic [7:0]          ledg,
    output logic [6:0]          hex0,
    output logic [6:0]          hex1,
    output logic [6:0]          hex2,
    output logic [6:0]          hex3,
    input  logic                mic_sd,
    output logic                mic_sck,
    output logic                mic_ws,
    output logic                mic_lr
);

    logic [`W_KEY - 1:0]        lab_key;
    logic [`W_SW  - 2:0]        lab_sw;
    logic [`W_BAR - 1:0]        lab_led;
    seg_bus_t                   lab_seg;
    logic [7:0]                 hgfedcba;
    logic [`W_DIGIT - 1:0][6:0] hex_q;
    logic [`W_DIGIT - 1:0]      dp_q;

    assign lab_key = ~key_n;                  // Keys are active low
    assign lab_sw  = sw[`W_SW - 2:0];         // Top switch not passed down

    // --------------------------------------------------

    lab_top i_lab_top
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key     ( lab_key ),
        .sw      ( lab_sw  ),
        .led     ( lab_led ),
        .seg     ( lab_seg ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  )
    );

    assign mic_lr = 1'b0;                     // Left channel

    // --------------------------------------------------
    // Static digits from the scanned bus

    // HEX pins run segment a on bit 0
    always_comb
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = lab_seg.abcdefgh[7 - i];

    // Each digit keeps its last glyph between strobes
    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            hex_q <= '1;                      // Blank
            dp_q  <= '0;
        end
        else
            for (int i = 0; i < `W_DIGIT; i++)
                if (lab_seg.digit[i])
                begin
                    hex_q[i] <= ~hgfedcba[6:0];
                    dp_q[i]  <=  hgfedcba[7];
                end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

    // --------------------------------------------------
    // LED pins

    assign {ledr[9 - `W_DIGIT:0], ledg} = lab_led;
    assign ledr[9 -: `W_DIGIT]          = dp_q;

endmodule

`default_nettype wire

// ==== testbench/board_top_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module board_top_props
(
    input logic                        clk,
    input logic                        rst,
    input logic [`W_DIGIT - 1:0]       digit,
    input logic                        mic_sck,
    input logic                        mic_ws,
    input logic [`W_DIGIT - 1:0][6:0]  hex
);

    int error_count = 0;                // Read by the testbench at the end

    digit_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot(digit))
    else
    begin
        $error("Digit strobe %b is not one-hot", digit);
        error_count++;
    end

    ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst)
                                     $changed(mic_ws) |-> $fell(mic_sck))
    else
    begin
        $error("Word select changed away from a falling bit clock");
        error_count++;
    end

    hex_blank_in_reset: assert property (@(posedge clk) rst |-> (hex == '1))
    else
    begin
        $error("Hex outputs not blank during reset");
        error_count++;
    end

endmodule

`default_nettype wire

// ==== testbench/tb_board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mic_meter_defs.svh"

module tb_board_top
    import mic_meter_pkg::*;
();

    localparam string case_file = "testbench/mic_meter_cases.txt";

    logic                      clk;
    logic                      rst;
    logic [`W_KEY - 1:0]       key_n;
    logic [`W_SW  - 1:0]       sw;
    logic [9:0]                ledr;
    logic [7:0]                ledg;
    logic [6:0]                hex0, hex1, hex2, hex3;
    logic                      mic_sd, mic_sck, mic_ws, mic_lr;
    logic [`W_DIGIT - 1:0][6:0] hex_all;

    string                     case_name   [$];
    logic [`W_SAMPLE - 1:0]    case_sample [$];
    logic                      case_mode   [$];
    logic                      case_clear  [$];
    logic [15:0]               case_word   [$];
    int                        case_bar    [$];

    int                        error_count  = 0;
    int                        tests_passed = 0;
    int                        tests_failed = 0;
    int                        limit_ns     = 0;
    int                        errors_before;
    int                        total_errors;

    logic [`W_SAMPLE - 1:0]    mic_word;    // Word the microphone model sends
    logic [`W_SAMPLE - 1:0]    frame_word;
    int                        frame_pos;
    logic                      prev_ws;

    assign hex_all = {hex3, hex2, hex1, hex0};

    board_top dut0
    (
        .clk     ( clk     ),
        .rst     ( rst     ),
        .key_n   ( key_n   ),
        .sw      ( sw      ),
        .ledr    ( ledr    ),
        .ledg    ( ledg    ),
        .hex0    ( hex0    ),
        .hex1    ( hex1    ),
        .hex2    ( hex2    ),
        .hex3    ( hex3    ),
        .mic_sd  ( mic_sd  ),
        .mic_sck ( mic_sck ),
        .mic_ws  ( mic_ws  ),
        .mic_lr  ( mic_lr  )
    );

    bind board_top board_top_props props0
    (
        .clk     ( clk           ),
        .rst     ( rst           ),
        .digit   ( lab_seg.digit ),
        .mic_sck ( mic_sck       ),
        .mic_ws  ( mic_ws        ),
        .hex     ( hex_q         )
    );

    // --------------------------------------------------
    // Clock and I2S microphone model

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Data changes on the first falling clk edge after each falling bit clock edge
    initial
    begin
        void'($urandom(32'h90031d66));
        forever
        begin
            @(negedge mic_sck);
            @(negedge clk);
            if (prev_ws && !mic_ws)
            begin
                frame_pos  = 0;
                frame_word = mic_word;      // New frame picks up the word
            end
            else
                frame_pos = frame_pos + 1;
            prev_ws = mic_ws;
            if (mic_ws)
                mic_sd = 1'($urandom % 2);  // Right slot padding
            else if (frame_pos >= 1 && frame_pos <= `W_SAMPLE)
                mic_sd = frame_word[`W_SAMPLE - frame_pos];
            else
                mic_sd = 1'b0;
        end
    end

    // --------------------------------------------------
    // Expected values and checks

    function automatic logic [6:0] hex_glyph(input logic [3:0] nib);
        case (nib)                          // Active low with segment a on bit 0
            4'h0:    hex_glyph = 7'h40;
            4'h1:    hex_glyph = 7'h79;
            4'h2:    hex_glyph = 7'h24;
            4'h3:    hex_glyph = 7'h30;
            4'h4:    hex_glyph = 7'h19;
            4'h5:    hex_glyph = 7'h12;
            4'h6:    hex_glyph = 7'h02;
            4'h7:    hex_glyph = 7'h78;
            4'h8:    hex_glyph = 7'h00;
            4'h9:    hex_glyph = 7'h10;
            4'ha:    hex_glyph = 7'h08;
            4'hb:    hex_glyph = 7'h03;
            4'hc:    hex_glyph = 7'h46;
            4'hd:    hex_glyph = 7'h21;
            4'he:    hex_glyph = 7'h06;
            default: hex_glyph = 7'h0e;
        endcase
    endfunction

    function automatic logic [`W_BAR - 1:0] bar_leds(input int count);
        bar_leds = '0;
        for (int i = 0; i < count && i < `W_BAR; i++)
            bar_leds[i] = 1'b1;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string test);
        if (error_count == errors_before)
        begin
            tests_passed++;
            $display("PASS  %s", test);
        end
        else
        begin
            tests_failed++;
            $display("FAIL  %s", test);
        end
    endtask

    // Lines starting with # are comments and the rest hold six columns
    task automatic read_cases();
        int                     fd;
        int                     ch;
        string                  tok;
        logic [`W_SAMPLE - 1:0] smp;
        logic [15:0]            wrd;
        int                     md, clr, bar;
        fd = $fopen(case_file, "r");
        if (fd == 0)
        begin
            $display("Cannot open the case file %s", case_file);
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1)
        begin
            if (tok.getc(0) == "#")
            begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
            end
            else if ($fscanf(fd, "%h %d %d %h %d", smp, md, clr, wrd, bar) == 5)
            begin
                case_name.push_back(tok);
                case_sample.push_back(smp);
                case_mode.push_back(md[0]);
                case_clear.push_back(clr[0]);
                case_word.push_back(wrd);
                case_bar.push_back(bar);
            end
            else
            begin
                $display("Case file entry %s has missing or bad columns", tok);
                error_count++;
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // Test sequence

    initial
    begin
        rst        = 1'b1;
        key_n      = '1;
        sw         = '0;
        mic_sd     = 1'b0;
        mic_word   = '0;
        frame_word = '0;
        frame_pos  = 63;
        prev_ws    = 1'b1;
        read_cases();
        if (case_name.size() == 0)
        begin
            $display("No usable test cases were found");
            $display("Test failed");
            $finish;
        end
        else
        begin
            limit_ns = case_name.size() * 4 * 512 * 4 + 4000;
            repeat (10) @(negedge clk);
            rst = 1'b0;
            @(negedge clk);
            errors_before = error_count;
            for (int d = 0; d < `W_DIGIT; d++)
                check_value("reset_blank", $sformatf("hex%0d", d), 7'h7f, hex_all[d]);
            check_value("reset_blank", "ledr", 10'h000, ledr);
            check_value("reset_blank", "ledg", 8'h00, ledg);
            check_value("reset_blank", "mic_lr", 1'b0, mic_lr);
            report_test("reset_blank");
            for (int i = 0; i < case_name.size(); i++)
            begin
                errors_before = error_count;
                sw[0]    = case_mode[i];
                mic_word = case_sample[i];
                @(negedge mic_ws);          // Older samples have all landed
                @(negedge clk);
                key_n[0] = ~case_clear[i];
                repeat (2) @(negedge mic_ws);
                repeat (4 * `SCAN_DIV + 2) @(negedge clk);
                for (int d = 0; d < `W_DIGIT; d++)
                    check_value(case_name[i], $sformatf("hex%0d", d),
                                hex_glyph(case_word[i][d * 4 +: 4]), hex_all[d]);
                check_value(case_name[i], "bar", bar_leds(case_bar[i]), {ledr[5:0], ledg});
                check_value(case_name[i], "dp", {3'b000, case_mode[i]}, ledr[9:6]);
                report_test(case_name[i]);
            end
            total_errors = error_count + dut0.props0.error_count;
            if (dut0.props0.error_count != 0)
                $display("%0d assertion failures in board_top_props", dut0.props0.error_count);
            $display("Tests: %0d run, %0d passed, %0d failed",
                     tests_passed + tests_failed, tests_passed, tests_failed);
            if (total_errors == 0)
                $display("Test completed successfully");
            else
                $display("Test failed");
            $finish;
        end
    end

    // Watchdog sized from the number of cases
    initial
    begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Watchdog expired after %0d ns with tests still running", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/mic_meter_cases.txt ====
# name sample mode clear shown_word bar_leds
# sample and shown_word in hex, mode, clear and bar_leds in decimal
pos_small     012345 0 0 0123  8
neg_small     fedcba 0 0 fedc  8
pos_big       3a5f00 0 0 3a5f 13
peak_show     001000 1 0 74be 13
peak_holds    f00000 1 0 74be 13
clear_peak    200000 1 1 0000  0
after_clear   000100 1 0 0002  0
bar_one       000200 1 0 0004  1
bar_seven     00c000 0 0 00c0  7
neg_saturate  800000 1 0 ffff 14
pos_full      7fffff 0 0 7fff 14
clear_raw     abcdef 0 1 abcd  0
neg_tiny      ffff80 1 0 0001  0
bar_four      001800 1 0 0030  4
bar_eleven    0f0000 0 0 0f00 11
neg_bar       e00000 1 0 4000 13

// ==== verilog.f ====
+incdir+hdl
hdl/mic_meter_pkg.sv
hdl/i2s_mic_receiver.sv
hdl/level_tracker.sv
hdl/seg_scan_display.sv
hdl/lab_top.sv
hdl/board_top.sv
testbench/board_top_props.sv
testbench/tb_board_top.sv
